// File: list.f
src/motion_pkg.sv
src/command_decoder.sv
src/move_sequencer.sv
src/dda_axis.sv
src/step_tally.sv
src/motion_top.sv
sim/motion_sva.sv
sim/tb_motion_top.sv

// File: Bender.yml
package:
  name: motion_core

sources:
  - src/motion_pkg.sv
  - src/command_decoder.sv
  - src/move_sequencer.sv
  - src/dda_axis.sv
  - src/step_tally.sv
  - src/motion_top.sv
  - target: simulation
    files:
      - sim/motion_sva.sv
      - sim/tb_motion_top.sv

// File: sim/tb_motion_top.sv
// Testbench for the motion core with stimulus table, reference DDA model and compare tasks
`timescale 1ns/1ps

module tb_motion_top import motion_pkg::*; ;

  localparam int NUM_AXES    = 3;
  localparam int BUFFER_SIZE = 2;
  localparam int NUM_FIXED   = 9;
  localparam int NUM_RANDOM  = 6;
  localparam int NUM_ENTRIES = NUM_FIXED + NUM_RANDOM;
  localparam int MOVE_WORDS  = 2 + 2 * NUM_AXES;

  typedef enum logic [2:0] {K_INFO, K_UNKNOWN, K_ENABLE, K_DIV, K_MOVE, K_QUEUE} kind_t;

  typedef struct packed {
    kind_t                     kind;
    divisor_t                  divisor;   // Divisor in effect, or the new one for K_DIV
    logic [NUM_AXES-1:0]       dir;       // Enable bits for K_ENABLE
    duration_t                 duration;
    axis_rate_t [NUM_AXES-1:0] axes;
  } entry_t;

  typedef tally_t [NUM_AXES-1:0] counts_t;

  logic                CLK;
  logic                resetn;
  bus_word_t           word_data;
  logic                word_strobe;
  bus_word_t           word_reply;
  logic [NUM_AXES-1:0] step;
  logic [NUM_AXES-1:0] dir;
  logic [NUM_AXES-1:0] enable;
  logic                buffer_dtr;
  logic                move_done;

  entry_t              stim [NUM_ENTRIES];
  counts_t             seen_q[$];        // Step counts per finished move
  counts_t             expect_q[$];
  logic [NUM_AXES-1:0] seen_dir_q[$];
  logic [NUM_AXES-1:0] expect_dir_q[$];
  counts_t             live_steps;
  counts_t             model_tally;      // Signed running position per axis
  int                  seed = 66641;
  int                  sent_cnt = 0;
  int                  done_cnt = 0;
  int                  checked = 0;
  int                  cycle_cnt = 0;
  int                  cycle_limit = 1000000;
  int                  cur_div = 32;     // Divisor the host last wrote
  int                  step_gap = -1;    // Cycles since the previous step of this move
  int                  err_word = 0;
  int                  err_tally = 0;
  int                  err_bits = 0;
  int                  err_flag = 0;
  int                  err_other = 0;

  motion_top #(
    .NUM_AXES    (NUM_AXES),
    .BUFFER_SIZE (BUFFER_SIZE)
  ) u_motion_top (
    .CLK         (CLK),
    .resetn      (resetn),
    .word_data   (word_data),
    .word_strobe (word_strobe),
    .word_reply  (word_reply),
    .step        (step),
    .dir         (dir),
    .enable      (enable),
    .buffer_dtr  (buffer_dtr),
    .move_done   (move_done)
  );

  initial CLK = 1'b0;
  always #2 CLK = ~CLK;

  // Port monitor that closes a move on move_done
  always @(posedge CLK) begin
    if (!resetn) begin
      if (step_gap >= 0) step_gap = step_gap + 1;
      if (|step) begin
        // Steps follow ticks, so pulses sit on the divisor grid
        if (step_gap > 0 && step_gap % (cur_div + 1) != 0) begin
          err_other++;
          $display("Step pulses came %0d cycles apart, not a multiple of divisor %0d plus 1",
                   step_gap, cur_div);
        end
        step_gap = 0;
      end
      for (int i = 0; i < NUM_AXES; i++) begin
        if (step[i]) live_steps[i] = live_steps[i] + 1;
      end
      if (move_done) begin
        seen_q.push_back(live_steps);  // Last step shares the cycle with move_done
        seen_dir_q.push_back(dir);
        live_steps = '0;
        step_gap   = -1;
        done_cnt   = done_cnt + 1;
      end
    end
  end

  always @(posedge CLK) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
      $display("Timeout: run did not complete within %0d cycles", cycle_limit);
      $display("Test failed");
      $finish;
    end
  end

  task automatic check_word(input string name, input bus_word_t got, input bus_word_t exp);
    if (got !== exp) begin
      err_word++;
      $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
    end
  endtask

  task automatic check_tally(input string name, input tally_t got, input tally_t exp);
    if (got !== exp) begin
      err_tally++;
      $display("MISMATCH t=%0t %s got=%0d exp=%0d", $time, name, got, exp);
    end
  endtask

  task automatic check_bits(input string name, input logic [NUM_AXES-1:0] got,
                            input logic [NUM_AXES-1:0] exp);
    if (got !== exp) begin
      err_bits++;
      $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      err_flag++;
      $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
    end
  endtask

  // Steps of one axis over a move when ticked per the DDA rule
  function automatic tally_t dda_steps(dda_rate_t rate, dda_rate_t accel, duration_t dur);
    logic [DDA_W:0]   sum;
    logic [DDA_W-1:0] acc;
    dda_rate_t        r;
    tally_t           n;
    acc = '0;
    r   = rate;
    n   = 0;
    for (int t = 0; t < dur; t++) begin
      sum = {1'b0, acc} + {1'b0, r};
      if (sum[DDA_W]) n++;
      acc = sum[DDA_W-1:0];
      r   = r + accel;
    end
    return n;
  endfunction

  // Called on a falling edge with the strobe high 2 cycles then low 2
  task automatic send_word(input bus_word_t w, output bus_word_t reply);
    word_data   = w;
    word_strobe = 1'b1;
    repeat (2) @(negedge CLK);
    reply       = word_reply;
    word_strobe = 1'b0;
    repeat (2) @(negedge CLK);
  endtask

  task automatic send_move(input entry_t e);
    bus_word_t reply;
    bit        idle;
    counts_t   cnt;
    while (!buffer_dtr) @(negedge CLK);
    idle = (sent_cnt == done_cnt);  // Snapshot is exact only with no move running
    send_word({CMD_COORDINATED_STEP, {(WORD_W - 8 - NUM_AXES){1'b0}}, e.dir}, reply);
    check_word("word_reply", reply, '0);
    send_word(bus_word_t'(e.duration), reply);
    if (idle) check_tally("tally_readback[0]", reply[31:0], model_tally[0]);
    for (int i = 0; i < NUM_AXES; i++) begin
      send_word(bus_word_t'(e.axes[i].rate), reply);
      send_word(bus_word_t'(e.axes[i].accel), reply);
      if (idle && i < NUM_AXES - 1) begin
        check_tally($sformatf("tally_readback[%0d]", i + 1), reply[31:0], model_tally[i + 1]);
      end
    end
    for (int i = 0; i < NUM_AXES; i++) begin
      cnt[i] = dda_steps(e.axes[i].rate, e.axes[i].accel, e.duration);
      model_tally[i] = e.dir[i] ? model_tally[i] + cnt[i] : model_tally[i] - cnt[i];
    end
    expect_q.push_back(cnt);
    expect_dir_q.push_back(e.dir);
    sent_cnt++;
  endtask

  task automatic finish_moves;
    counts_t             got;
    counts_t             exp;
    logic [NUM_AXES-1:0] got_dir;
    logic [NUM_AXES-1:0] exp_dir;
    if (sent_cnt - done_cnt >= BUFFER_SIZE) begin
      check_flag("buffer_dtr", buffer_dtr, 1'b0);  // Every slot holds a move
      while (done_cnt < sent_cnt - 1) @(negedge CLK);
      @(negedge CLK);
      check_flag("buffer_dtr", buffer_dtr, 1'b1);
    end
    while (done_cnt < sent_cnt) @(negedge CLK);
    while (expect_q.size() > 0) begin
      got     = seen_q.pop_front();
      exp     = expect_q.pop_front();
      got_dir = seen_dir_q.pop_front();
      exp_dir = expect_dir_q.pop_front();
      for (int i = 0; i < NUM_AXES; i++) begin
        check_tally($sformatf("move%0d steps[%0d]", checked, i), got[i], exp[i]);
      end
      check_bits($sformatf("move%0d dir", checked), got_dir, exp_dir);
      checked++;
    end
  endtask

  task automatic put_move(input int n, input kind_t k, input logic [NUM_AXES-1:0] d,
                          input duration_t dur, input dda_rate_t r0, input dda_rate_t a0,
                          input dda_rate_t r1, input dda_rate_t a1,
                          input dda_rate_t r2, input dda_rate_t a2);
    stim[n].kind     = k;
    stim[n].dir      = d;
    stim[n].duration = dur;
    stim[n].axes[0]  = '{rate: r0, accel: a0};
    stim[n].axes[1]  = '{rate: r1, accel: a1};
    stim[n].axes[2]  = '{rate: r2, accel: a2};
  endtask

  task automatic build_table;
    divisor_t div;
    for (int n = 0; n < NUM_ENTRIES; n++) stim[n] = '0;
    stim[0].kind = K_INFO;
    stim[1].kind = K_UNKNOWN;
    stim[2].kind = K_ENABLE;
    stim[2].dir  = 3'b101;
    stim[3].kind = K_ENABLE;
    stim[3].dir  = 3'b010;
    put_move(4, K_MOVE, 3'b101, 12, 32'h4000_0000, 0, 32'h1000_0000, 32'h0080_0000,
             32'h6000_0000, -32'sh0100_0000);
    stim[5].kind    = K_DIV;
    stim[5].divisor = 8'd3;
    put_move(6, K_MOVE, 3'b101, 12, 32'h4000_0000, 0, 32'h1000_0000, 32'h0080_0000,
             32'h6000_0000, -32'sh0100_0000);
    // Long first move keeps both slots busy
    put_move(7, K_QUEUE, 3'b011, 30, 32'h2800_0000, 0, 32'h0C00_0000, 32'h0010_0000,
             32'h5555_5555, 0);
    put_move(8, K_MOVE, 3'b110, 9, 32'h3000_0000, -32'sh0004_0000, 32'h7000_0000, 0,
             32'h1800_0000, 32'h0200_0000);
    for (int n = NUM_FIXED; n < NUM_ENTRIES; n++) begin
      stim[n].kind     = K_MOVE;
      stim[n].dir      = NUM_AXES'($random(seed));
      stim[n].duration = 1 + ($unsigned($random(seed)) % 40);
      for (int i = 0; i < NUM_AXES; i++) begin
        stim[n].axes[i].rate  = $random(seed) & 32'h3FFF_FFFF;
        stim[n].axes[i].accel = $random(seed) % 4096;
      end
    end
    // Divisor in effect per entry and the cycle budget
    div         = 8'd32;
    cycle_limit = 0;
    for (int n = 0; n < NUM_ENTRIES; n++) begin
      if (stim[n].kind == K_DIV) div = stim[n].divisor;
      stim[n].divisor = div;
      cycle_limit += (stim[n].duration + 1) * (div + 1);
      cycle_limit += 64 * ((stim[n].kind >= K_MOVE) ? MOVE_WORDS : 1);
    end
    cycle_limit = 2 * cycle_limit;
  endtask

  initial begin
    entry_t    e;
    bus_word_t reply;
    int        sva_fails;
    resetn      = 1'b1;
    word_data   = '0;
    word_strobe = 1'b0;
    live_steps  = '0;
    model_tally = '0;
    build_table();
    repeat (3) @(posedge CLK);
    @(negedge CLK);
    check_bits("step", step, '0);
    check_bits("dir", dir, '0);
    check_bits("enable", enable, '0);
    check_flag("move_done", move_done, 1'b0);
    check_flag("buffer_dtr", buffer_dtr, 1'b1);
    check_word("word_reply", word_reply, '0);
    resetn = 1'b0;

    for (int n = 0; n < NUM_ENTRIES; n++) begin
      e = stim[n];
      case (e.kind)
        K_INFO: begin
          send_word({CMD_CHANNEL_INFO, 56'h0}, reply);
          check_word("channel_info", reply, {40'h0, 8'd32, 8'd32, 8'(NUM_AXES)});
        end
        K_UNKNOWN: begin
          send_word(64'h5500_0000_0000_0FFF, reply);
          check_word("unknown_reply", reply, '0);
        end
        K_ENABLE: begin
          send_word({CMD_MOTOR_ENABLE, {(WORD_W - 8 - NUM_AXES){1'b0}}, e.dir}, reply);
          check_bits("enable", enable, e.dir);
        end
        K_DIV: begin
          send_word({CMD_CLK_DIVISOR, 48'h0, e.divisor}, reply);
          cur_div = e.divisor;
        end
        K_MOVE: begin
          send_move(e);
          finish_moves();
        end
        K_QUEUE: begin
          send_move(e);  // Next move follows straight away
        end
        default: begin
        end
      endcase
    end

    repeat (8) @(negedge CLK);
    if (done_cnt != sent_cnt) begin
      err_other++;
      $display("move_done pulsed %0d times for %0d moves", done_cnt, sent_cnt);
    end
    sva_fails = u_motion_top.u_sequencer.u_sva.fails;
    $display("Errors: word %0d, tally %0d, bits %0d, flag %0d, other %0d, assertion %0d",
             err_word, err_tally, err_bits, err_flag, err_other, sva_fails);
    if (err_word + err_tally + err_bits + err_flag + err_other + sva_fails == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: sim/motion_sva.sv
// Concurrent assertions on move_done, slot writes and the load pulse, bound into move_sequencer
`timescale 1ns/1ps

module motion_sva import motion_pkg::*; (
  input logic       CLK,
  input logic       resetn,
  input logic       move_done,
  input logic       slot_write,
  input logic       buffer_dtr,
  input logic       load,
  input seq_state_t state
);

  int unsigned fails = 0;  // Assertion failures so far

  done_single: assert property (@(posedge CLK) disable iff (resetn) move_done |=> !move_done)
    else begin
      fails++;
      $error("move_done held high for two cycles");
    end

  // Host must wait for buffer_dtr
  no_write_full: assert property (@(posedge CLK) disable iff (resetn) slot_write |-> buffer_dtr)
    else begin
      fails++;
      $error("slot_write while every move slot is full");
    end

  load_from_idle: assert property (@(posedge CLK) disable iff (resetn)
      load |-> ($past(state) == SEQ_IDLE) ##1 (state == SEQ_RUN))
    else begin
      fails++;
      $error("load outside an idle to run transition");
    end

endmodule

bind move_sequencer motion_sva u_sva (
  .CLK        (CLK),
  .resetn     (resetn),
  .move_done  (move_done),
  .slot_write (slot_write),
  .buffer_dtr (buffer_dtr),
  .load       (load),
  .state      (state)
);

// File: src/motion_top.sv
// Motion core top level joining decoder, sequencer, DDA axes and step tally
`timescale 1ns/1ps

module motion_top import motion_pkg::*; #(
  parameter int NUM_AXES    = 3,
  parameter int BUFFER_SIZE = 2
) (
  input  logic                CLK,
  input  logic                resetn,
  input  bus_word_t           word_data,
  input  logic                word_strobe,
  output bus_word_t           word_reply,
  output logic [NUM_AXES-1:0] step,
  output logic [NUM_AXES-1:0] dir,
  output logic [NUM_AXES-1:0] enable,
  output logic                buffer_dtr,
  output logic                move_done
);

  divisor_t                       divisor;
  logic                           slot_write;
  logic [slot_bits(NUM_AXES)-1:0] slot_data;
  logic                           snapshot;
  tally_t [NUM_AXES-1:0]          tally_snap;
  logic                           tick;
  logic                           load;
  logic                           run;
  axis_rate_t [NUM_AXES-1:0]      axis_rate;

  command_decoder #(
    .NUM_AXES (NUM_AXES)
  ) u_decoder (
    .CLK         (CLK),
    .resetn      (resetn),
    .word_data   (word_data),
    .word_strobe (word_strobe),
    .word_reply  (word_reply),
    .enable      (enable),
    .divisor     (divisor),
    .slot_write  (slot_write),
    .slot_data   (slot_data),
    .snapshot    (snapshot),
    .tally_snap  (tally_snap)
  );

  move_sequencer #(
    .NUM_AXES    (NUM_AXES),
    .BUFFER_SIZE (BUFFER_SIZE)
  ) u_sequencer (
    .CLK        (CLK),
    .resetn     (resetn),
    .divisor    (divisor),
    .slot_write (slot_write),
    .slot_data  (slot_data),
    .buffer_dtr (buffer_dtr),
    .move_done  (move_done),
    .tick       (tick),
    .load       (load),
    .run        (run),
    .dir        (dir),
    .axis_rate  (axis_rate)
  );

  // One DDA per motor
  for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
    dda_axis u_dda (
      .CLK       (CLK),
      .resetn    (resetn),
      .tick      (tick),
      .load      (load),
      .run       (run),
      .axis_rate (axis_rate[i]),
      .step      (step[i])
    );
  end

  step_tally #(
    .NUM_AXES (NUM_AXES)
  ) u_tally (
    .CLK        (CLK),
    .resetn     (resetn),
    .step       (step),
    .dir        (dir),
    .snapshot   (snapshot),
    .tally_snap (tally_snap)
  );

endmodule

// File: src/step_tally.sv
// Signed per-axis step counters with a snapshot copy for host readback
`timescale 1ns/1ps

module step_tally import motion_pkg::*; #(
  parameter int NUM_AXES = 3
) (
  input  logic                  CLK,
  input  logic                  resetn,
  input  logic [NUM_AXES-1:0]   step,
  input  logic [NUM_AXES-1:0]   dir,
  input  logic                  snapshot,
  output tally_t [NUM_AXES-1:0] tally_snap
);

  tally_t [NUM_AXES-1:0] live;   // Running position per axis

  always_ff @(posedge CLK) begin
    if (resetn) begin
      live       <= '0;
      tally_snap <= '0;
    end else begin
      for (int i = 0; i < NUM_AXES; i++) begin
        if (step[i]) begin
          // dir high counts up
          live[i] <= dir[i] ? live[i] + tally_t'(1) : live[i] - tally_t'(1);
        end
      end
      if (snapshot) begin
        tally_snap <= live;  // Counts as of the move header
      end
    end
  end

endmodule

// File: src/dda_axis.sv
// Single DDA axis with accumulator and ramping rate that emits step pulses
`timescale 1ns/1ps

module dda_axis import motion_pkg::*; (
  input  logic       CLK,
  input  logic       resetn,
  input  logic       tick,
  input  logic       load,
  input  logic       run,
  input  axis_rate_t axis_rate,
  output logic       step
);

  logic [DDA_W-1:0] acc;
  dda_rate_t        rate;   // Current rate that ramps by accel every tick
  logic [DDA_W:0]   sum;    // Top bit is the carry out
  logic             advance;

  assign sum     = {1'b0, acc} + {1'b0, rate};
  assign advance = tick && run;

  // Accel comes straight from the running slot
  always_ff @(posedge CLK) begin
    if (load) begin
      acc  <= '0;
      rate <= axis_rate.rate;
    end else if (advance) begin
      acc  <= sum[DDA_W-1:0];
      rate <= rate + axis_rate.accel;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      step <= 1'b0;
    end else begin
      step <= advance && sum[DDA_W];  // Overflow gives one step
    end
  end

endmodule

// File: src/move_sequencer.sv
// Tick divider, move slot ring with ready flags and the move duration FSM
`timescale 1ns/1ps

module move_sequencer import motion_pkg::*; #(
  parameter int NUM_AXES    = 3,
  parameter int BUFFER_SIZE = 2
) (
  input  logic                           CLK,
  input  logic                           resetn,
  input  divisor_t                       divisor,
  input  logic                           slot_write,
  input  logic [slot_bits(NUM_AXES)-1:0] slot_data,
  output logic                           buffer_dtr,
  output logic                           move_done,
  output logic                           tick,
  output logic                           load,
  output logic                           run,
  output logic [NUM_AXES-1:0]            dir,
  output axis_rate_t [NUM_AXES-1:0]      axis_rate
);

  localparam int IDX_W = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;

  typedef struct packed {
    logic [NUM_AXES-1:0]       dir;
    duration_t                 duration;
    axis_rate_t [NUM_AXES-1:0] axes;
  } move_slot_t;

  move_slot_t             slots [BUFFER_SIZE];
  logic [BUFFER_SIZE-1:0] ready;      // Slot holds a move not yet run
  logic [IDX_W-1:0]       wr_idx;
  logic [IDX_W-1:0]       rd_idx;
  logic                   slot_full;
  logic                   slot_accept;
  divisor_t               div_cnt;
  duration_t              remaining;  // Ticks left in the running move
  seq_state_t             state;

  assign slot_full   = &ready;
  assign buffer_dtr  = ~slot_full;
  assign slot_accept = slot_write && !ready[wr_idx];  // Writes into a full ring are lost
  assign tick        = (div_cnt >= divisor);
  assign load        = (state == SEQ_LOAD);
  assign move_done   = (state == SEQ_RUN) && (remaining == '0);
  assign run         = (state == SEQ_RUN) && !move_done;
  assign axis_rate   = slots[rd_idx].axes;  // Stable while the slot runs

  always_ff @(posedge CLK) begin
    if (slot_accept) begin
      slots[wr_idx] <= slot_data;
    end
  end

  always_ff @(posedge CLK) begin
    if (resetn) begin
      div_cnt   <= '0;
      wr_idx    <= '0;
      rd_idx    <= '0;
      ready     <= '0;
      remaining <= '0;
      dir       <= '0;
      state     <= SEQ_IDLE;
    end else begin
      div_cnt <= tick ? '0 : div_cnt + 1'b1;

      if (slot_accept) begin
        ready[wr_idx] <= 1'b1;
        wr_idx <= (wr_idx == IDX_W'(BUFFER_SIZE - 1)) ? '0 : wr_idx + 1'b1;
      end

      case (state)
        SEQ_IDLE: begin
          if (ready[rd_idx]) state <= SEQ_LOAD;
        end
        SEQ_LOAD: begin
          remaining <= slots[rd_idx].duration;
          dir       <= slots[rd_idx].dir;
          state     <= SEQ_RUN;
        end
        SEQ_RUN: begin
          if (move_done) begin
            // Release the slot and move on in write order
            ready[rd_idx] <= 1'b0;
            rd_idx <= (rd_idx == IDX_W'(BUFFER_SIZE - 1)) ? '0 : rd_idx + 1'b1;
            state  <= SEQ_IDLE;
          end else if (tick) begin
            remaining <= remaining - 1'b1;
          end
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

endmodule

// File: src/command_decoder.sv
// Host word decoder with header handling, move assembly, reply word and config registers
`timescale 1ns/1ps

module command_decoder import motion_pkg::*; #(
  parameter int NUM_AXES = 3
) (
  input  logic                           CLK,
  input  logic                           resetn,
  input  bus_word_t                      word_data,
  input  logic                           word_strobe,
  output bus_word_t                      word_reply,
  output logic [NUM_AXES-1:0]            enable,
  output divisor_t                       divisor,
  output logic                           slot_write,
  output logic [slot_bits(NUM_AXES)-1:0] slot_data,
  output logic                           snapshot,
  input  tally_t [NUM_AXES-1:0]          tally_snap
);

  localparam int CNT_W = $clog2(2 * NUM_AXES + 2);
  localparam int AX_W  = (NUM_AXES > 1) ? $clog2(NUM_AXES) : 1;

  typedef struct packed {
    logic [NUM_AXES-1:0]       dir;
    duration_t                 duration;
    axis_rate_t [NUM_AXES-1:0] axes;
  } move_slot_t;

  move_slot_t       slot_q;     // Move being assembled
  logic             strobe_q;
  logic             word_rise;
  logic [7:0]       header;     // Header of the message in progress
  logic [CNT_W-1:0] word_cnt;   // Words taken so far
  logic             in_move;
  logic [AX_W-1:0]  axis_idx;
  logic [AX_W-1:0]  next_idx;
  logic             is_accel;
  logic             last_word;

  assign word_rise = word_strobe & ~strobe_q;
  assign in_move   = (header == CMD_COORDINATED_STEP);

  // Words 2 and 3 carry axis 0, words 4 and 5 axis 1 and so on
  assign axis_idx  = AX_W'((word_cnt - CNT_W'(2)) >> 1);
  assign next_idx  = axis_idx + 1'b1;
  assign is_accel  = word_cnt[0] && (word_cnt != CNT_W'(1));
  assign last_word = is_accel && (axis_idx == AX_W'(NUM_AXES - 1));
  assign slot_data = slot_q;

  always_ff @(posedge CLK) begin
    if (resetn) begin
      strobe_q   <= 1'b0;
      header     <= 8'h00;
      word_cnt   <= '0;
      word_reply <= '0;
      enable     <= '0;
      divisor    <= DEFAULT_DIVISOR;
      slot_write <= 1'b0;
      snapshot   <= 1'b0;
    end else begin
      strobe_q   <= word_strobe;
      slot_write <= 1'b0;
      snapshot   <= 1'b0;

      if (word_rise) begin
        word_reply <= '0;  // Zero unless a field is filled below

        if (!in_move) begin
          // New message header
          header   <= word_data[WORD_W-1:HDR_LSB];
          word_cnt <= CNT_W'(1);
          case (word_data[WORD_W-1:HDR_LSB])
            CMD_COORDINATED_STEP: begin
              slot_q.dir <= word_data[NUM_AXES-1:0];
              snapshot   <= 1'b1;  // Freeze tallies for the readback
            end
            CMD_MOTOR_ENABLE: begin
              enable <= word_data[NUM_AXES-1:0];
            end
            CMD_CLK_DIVISOR: begin
              divisor <= word_data[7:0];
            end
            CMD_CHANNEL_INFO: begin
              word_reply[7:0]   <= 8'(NUM_AXES);
              word_reply[15:8]  <= 8'(DDA_W);
              word_reply[23:16] <= 8'($bits(tally_t));
            end
            default: begin
              header <= 8'h00;
            end
          endcase
        end else begin
          // Body words of a coordinated move
          word_cnt <= word_cnt + 1'b1;
          if (word_cnt == CNT_W'(1)) begin
            slot_q.duration <= word_data[$bits(duration_t)-1:0];
            word_reply[$bits(tally_t)-1:0] <= tally_snap[0];
          end else if (!is_accel) begin
            slot_q.axes[axis_idx].rate <= word_data[DDA_W-1:0];
          end else begin
            slot_q.axes[axis_idx].accel <= word_data[DDA_W-1:0];
            if (last_word) begin
              header     <= 8'h00;
              word_cnt   <= '0;
              slot_write <= 1'b1;  // Slot is complete on the next cycle
            end else begin
              word_reply[$bits(tally_t)-1:0] <= tally_snap[next_idx];
            end
          end
        end
      end
    end
  end

endmodule

// File: src/motion_pkg.sv
// Shared widths, vector types, command codes, state encoding and the per-axis rate struct
package motion_pkg;

  localparam int WORD_W  = 64;
  localparam int HDR_LSB = 56;  // Header byte sits in bits 63..56
  localparam int DDA_W   = 32;

  typedef logic [WORD_W-1:0]       bus_word_t;
  typedef logic signed [DDA_W-1:0] dda_rate_t;   // Rate and acceleration
  typedef logic [31:0]             duration_t;   // Move length in ticks
  typedef logic signed [31:0]      tally_t;
  typedef logic [7:0]              divisor_t;

  localparam divisor_t DEFAULT_DIVISOR = 8'd32;

  typedef enum logic [7:0] {
    CMD_COORDINATED_STEP = 8'h01,
    CMD_MOTOR_ENABLE     = 8'h0A,
    CMD_CLK_DIVISOR      = 8'h20,
    CMD_CHANNEL_INFO     = 8'hFD
  } cmd_t;

  typedef struct packed {
    dda_rate_t rate;
    dda_rate_t accel;
  } axis_rate_t;

  typedef enum logic [1:0] {
    SEQ_IDLE,
    SEQ_LOAD,
    SEQ_RUN
  } seq_state_t;

  // Packed size of one move slot for n axes
  // Slot layout is dir, duration, then one axis_rate_t per axis
  function automatic int slot_bits(int n);
    return n + $bits(duration_t) + n * $bits(axis_rate_t);
  endfunction

endpackage
